// ==== src/pet_bus_config.svh ====
// Assumes a 64 MHz system clock, a 16-count CPU cycle (4 MHz Phi2) and a 3-cycle async SRAM access
`ifndef PET_BUS_CONFIG_SVH
`define PET_BUS_CONFIG_SVH

// System clock
`define SYS_CLOCK_MHZ 64         // Cycle figures below follow from this rate

// Bus widths of the 65C02 address and data buses
`define ADDR_WIDTH 16
`define DATA_WIDTH 8

// CPU cycle timing points
// Counted in system cycles from the edge that samples the grant
// All points must stay below 16 because the cycle counter is 4 bits wide
`define CPU_BE_START 1           // BE rises, earlier bus owner has drained
`define CPU_PHI_START 5          // Phi2 rises once BE setup has elapsed
`define CPU_PHI_END 9            // Phi2 falls after minimum high width
`define CPU_BE_END 13            // BE falls after data hold

// SRAM access
// Pins stay driven this many cycles
// The write pulse sits in the middle cycle so address and data surround it
`define RAM_ACCESS_CYCLES 3

`endif

// ==== src/pet_bus_pkg.sv ====
// Shared owner type and ns-to-cycle rounding; results are only exact for integer MHz clock rates
`include "pet_bus_config.svh"
`default_nettype none

package pet_bus_pkg;

    // Who holds the current SRAM access
    typedef enum logic {
        OWNER_CPU    = 1'b0,    // Access on behalf of the 65C02
        OWNER_BRIDGE = 1'b1     // Access on behalf of the host bridge
    } bus_owner_t;

    // Data-sheet time to whole system cycles
    // Rounds up so a figure is never undercut
    // Integer only, usable in constant expressions
    function automatic int ns_to_cycles(input int time_ns);
        int scaled;
        scaled = time_ns * `SYS_CLOCK_MHZ;      // ns x MHz gives thousandths of a cycle
        return (scaled + 999) / 1000;           // Ceiling divide
    endfunction

endpackage

`default_nettype wire

// ==== src/cpu_bus_timing.sv ====
// One grant gives one 16-cycle CPU cycle; a grant while the counter runs is an error, not queued
`include "pet_bus_config.svh"
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_timing (
    input  logic sys_clock_i,
    input  logic rst_n_i,
    input  logic cpu_grant_i,   // One-cycle pulse, CPU must be suspended
    output logic cpu_be_o,      // Bus enable window
    output logic cpu_clock_o,   // Phi2
    output logic cpu_strobe_o,  // Transfer strobe with Phi2 rise
    output logic cpu_done_o     // Cycle finished
);
    // Timing points at counter width
    localparam logic [3:0] CNT_SUSPENDED = 4'd0;
    localparam logic [3:0] CNT_BE_START  = 4'(`CPU_BE_START);
    localparam logic [3:0] CNT_PHI_START = 4'(`CPU_PHI_START);
    localparam logic [3:0] CNT_PHI_END   = 4'(`CPU_PHI_END);
    localparam logic [3:0] CNT_BE_END    = 4'(`CPU_BE_END);
    localparam logic [3:0] CNT_LAST      = 4'hf;

    // W65C02S data-sheet figures in ns
    localparam int CPU_TBVD_NS = 30;    // BE to valid data
    localparam int CPU_TDSR_NS = 15;    // Data setup before Phi2 rise
    localparam int CPU_TPWH_NS = 62;    // Phi2 high pulse width

    // Same figures in system cycles
    localparam int BE_LEAD_MIN  = pet_bus_pkg::ns_to_cycles(CPU_TBVD_NS + CPU_TDSR_NS);
    localparam int PHI_HIGH_MIN = pet_bus_pkg::ns_to_cycles(CPU_TPWH_NS);

    logic [3:0] cycle_count;    // Position within the CPU cycle
    logic       cycle_last;     // Counter is wrapping back to rest

    // Rests at zero, one grant runs it once around
    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            cycle_count <= CNT_SUSPENDED;
        end else if (cycle_count != CNT_SUSPENDED || cpu_grant_i) begin
            cycle_count <= cycle_count + 4'd1;     // Wraps 15 -> 0 to suspend again
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            cpu_be_o     <= 1'b0;
            cpu_clock_o  <= 1'b0;
            cpu_strobe_o <= 1'b0;
            cycle_last   <= 1'b0;
            cpu_done_o   <= 1'b0;
        end else begin
            cpu_strobe_o <= (cycle_count == CNT_PHI_START);  // Single cycle with Phi2 rise
            cycle_last   <= (cycle_count == CNT_LAST);
            cpu_done_o   <= cycle_last;                      // One cycle after the wrap

            case (cycle_count)
                CNT_BE_START:  cpu_be_o    <= 1'b1;   // Previous RAM access is over
                CNT_PHI_START: cpu_clock_o <= 1'b1;   // BE setup met
                CNT_PHI_END:   cpu_clock_o <= 1'b0;   // High width met, CPU advances
                CNT_BE_END:    cpu_be_o    <= 1'b0;   // Address and data hold met
                default: begin
                end
            endcase
        end
    end

    // Phi2 only pulses inside the bus window
    a_clock_in_be: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        cpu_clock_o |-> cpu_be_o);

    // Scheduler only grants a suspended CPU
    a_grant_idle: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        cpu_grant_i |-> (cycle_count == CNT_SUSPENDED));

    // BE leads Phi2 by at least tBVD + tDSR
    a_be_lead: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        $rose(cpu_be_o) |-> !cpu_clock_o [*BE_LEAD_MIN]);

    // Phi2 high for at least tPWH
    a_phi_high: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        $rose(cpu_clock_o) |-> cpu_clock_o [*PHI_HIGH_MIN]);

endmodule

`default_nettype wire

// ==== src/bus_scheduler.sv ====
// Bridge requests are levels held until bridge_done_o; a bridge slot always precedes a CPU slot
`timescale 1ns/10ps
`default_nettype none

module bus_scheduler (
    input  logic                   sys_clock_i,
    input  logic                   rst_n_i,
    input  logic                   cpu_run_i,       // Level, CPU slots only while high
    input  logic                   bridge_req_i,    // Level, held until done
    input  logic                   cpu_strobe_i,    // From CPU timing
    input  logic                   cpu_done_i,      // From CPU timing
    input  logic                   ram_done_i,      // From RAM sequencer
    output logic                   cpu_grant_o,     // One-cycle pulse
    output logic                   ram_start_o,     // One-cycle pulse
    output logic                   bridge_done_o,   // One-cycle pulse
    output pet_bus_pkg::bus_owner_t ram_owner_o
);
    // FSM encoding
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_BRIDGE = 2'd1;
    localparam logic [1:0] ST_CPU    = 2'd2;

    logic [1:0] state_q;
    logic       grant_q;            // Grant pulse on entry to CPU slot
    logic       bridge_start_q;     // Start pulse on entry to bridge slot
    logic       access_busy_q;      // SRAM access between start and done

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            state_q        <= ST_IDLE;
            grant_q        <= 1'b0;
            bridge_start_q <= 1'b0;
        end else begin
            grant_q        <= 1'b0;    // Pulses by default
            bridge_start_q <= 1'b0;

            case (state_q)
                ST_IDLE: begin
                    // Bridge first in every round
                    if (bridge_req_i) begin
                        state_q        <= ST_BRIDGE;
                        bridge_start_q <= 1'b1;
                    end else if (cpu_run_i) begin
                        state_q <= ST_CPU;
                        grant_q <= 1'b1;
                    end
                end
                ST_BRIDGE: begin
                    // CPU stays suspended until the bridge access completes
                    if (ram_done_i) begin
                        if (cpu_run_i) begin
                            state_q <= ST_CPU;     // Rest of the round
                            grant_q <= 1'b1;
                        end else begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                ST_CPU: begin
                    if (cpu_done_i) begin
                        state_q <= ST_IDLE;        // Waiting bridge request goes next
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Tracks one outstanding access for the overlap check
    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            access_busy_q <= 1'b0;
        end else if (ram_start_o) begin
            access_busy_q <= 1'b1;
        end else if (ram_done_i) begin
            access_busy_q <= 1'b0;
        end
    end

    assign cpu_grant_o   = grant_q;
    assign ram_start_o   = bridge_start_q | ((state_q == ST_CPU) & cpu_strobe_i); // Strobe passes through
    assign bridge_done_o = (state_q == ST_BRIDGE) & ram_done_i;
    assign ram_owner_o   = (state_q == ST_CPU) ? pet_bus_pkg::OWNER_CPU
                                               : pet_bus_pkg::OWNER_BRIDGE;

    // Sequencer never gets a second start before it finishes
    a_no_overlap: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        ram_start_o |-> !access_busy_q);

endmodule

`default_nettype wire

// ==== src/ram_sequencer.sv ====
// Fixed-length async SRAM access; owner inputs are sampled once at start and must not overlap
`include "pet_bus_config.svh"
`timescale 1ns/10ps
`default_nettype none

module ram_sequencer (
    input  logic                    sys_clock_i,
    input  logic                    rst_n_i,
    input  logic                    ram_start_i,     // One-cycle pulse
    input  pet_bus_pkg::bus_owner_t ram_owner_i,     // Valid with start
    input  logic [`ADDR_WIDTH-1:0]  cpu_addr_i,
    input  logic                    cpu_we_i,
    input  logic [`DATA_WIDTH-1:0]  cpu_data_i,
    input  logic [`ADDR_WIDTH-1:0]  bridge_addr_i,
    input  logic                    bridge_we_i,
    input  logic [`DATA_WIDTH-1:0]  bridge_wdata_i,
    input  logic [`DATA_WIDTH-1:0]  ram_rdata_i,     // Async SRAM output
    output logic [`ADDR_WIDTH-1:0]  ram_addr_o,
    output logic [`DATA_WIDTH-1:0]  ram_wdata_o,
    output logic                    ram_oe_o,
    output logic                    ram_we_o,
    output logic                    ram_done_o,      // One-cycle pulse
    output logic [`DATA_WIDTH-1:0]  cpu_data_o,      // CPU read register
    output logic [`DATA_WIDTH-1:0]  bridge_rdata_o   // Bridge read register
);
    localparam int STEP_W = $clog2(`RAM_ACCESS_CYCLES);

    // Steps count driven cycles from zero, compares happen one edge ahead
    localparam logic [STEP_W-1:0] STEP_WE_SET  = STEP_W'((`RAM_ACCESS_CYCLES - 1) / 2 - 1);
    localparam logic [STEP_W-1:0] STEP_CAPTURE = STEP_W'(`RAM_ACCESS_CYCLES - 2);
    localparam logic [STEP_W-1:0] STEP_LAST    = STEP_W'(`RAM_ACCESS_CYCLES - 1);

    logic                    active_q;   // Pins driven
    logic [STEP_W-1:0]       step_q;     // Current driven cycle
    logic                    we_q;       // Latched direction
    pet_bus_pkg::bus_owner_t owner_q;    // Latched owner, picks read register
    logic                    start_cpu;  // Start belongs to the CPU
    logic                    start_we;   // Direction of the starting owner

    assign start_cpu = (ram_owner_i == pet_bus_pkg::OWNER_CPU);
    assign start_we  = start_cpu ? cpu_we_i : bridge_we_i;

    // Control state
    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            active_q   <= 1'b0;
            step_q     <= '0;
            ram_oe_o   <= 1'b0;
            ram_we_o   <= 1'b0;
            ram_done_o <= 1'b0;
        end else begin
            // Write pulse only in the middle cycle
            ram_we_o   <= active_q && we_q && (step_q == STEP_WE_SET);
            ram_done_o <= active_q && (step_q == STEP_CAPTURE);   // Same edge as capture

            if (ram_start_i) begin
                active_q <= 1'b1;
                step_q   <= '0;
                ram_oe_o <= !start_we;          // OE for the whole read
            end else if (active_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == STEP_LAST) begin
                    active_q <= 1'b0;           // Release pins
                    ram_oe_o <= 1'b0;
                end
            end
        end
    end

    // Address, data and direction of the selected owner
    always_ff @(posedge sys_clock_i) begin
        if (ram_start_i) begin
            owner_q     <= ram_owner_i;
            we_q        <= start_we;
            ram_addr_o  <= start_cpu ? cpu_addr_i : bridge_addr_i;
            ram_wdata_o <= start_cpu ? cpu_data_i : bridge_wdata_i;
        end
    end

    // Read data lands in the owner's register and holds until its next read
    always_ff @(posedge sys_clock_i) begin
        if (active_q && !we_q && step_q == STEP_CAPTURE) begin
            if (owner_q == pet_bus_pkg::OWNER_CPU) begin
                cpu_data_o <= ram_rdata_i;      // Ahead of the Phi2 fall
            end else begin
                bridge_rdata_o <= ram_rdata_i;
            end
        end
    end

    // SRAM never sees output enable during a write pulse
    a_oe_we_excl: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        !(ram_oe_o && ram_we_o));

endmodule

`default_nettype wire

// ==== src/pet_bus_top.sv ====
// Bus core only, no tri-state pins; CPU pins must hold address and data while cpu_be_o is high
`include "pet_bus_config.svh"
`timescale 1ns/10ps
`default_nettype none

module pet_bus_top (
    input  logic                   sys_clock_i,
    input  logic                   rst_n_i,
    input  logic                   cpu_run_i,        // Enables CPU slots
    // Host bridge
    input  logic                   bridge_req_i,
    input  logic                   bridge_we_i,
    input  logic [`ADDR_WIDTH-1:0] bridge_addr_i,
    input  logic [`DATA_WIDTH-1:0] bridge_wdata_i,
    output logic                   bridge_done_o,
    output logic [`DATA_WIDTH-1:0] bridge_rdata_o,
    // 65C02 pins
    output logic                   cpu_be_o,
    output logic                   cpu_clock_o,      // Phi2
    input  logic [`ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic                   cpu_we_i,
    input  logic [`DATA_WIDTH-1:0] cpu_data_i,
    output logic [`DATA_WIDTH-1:0] cpu_data_o,
    // Async SRAM pins
    output logic [`ADDR_WIDTH-1:0] ram_addr_o,
    output logic [`DATA_WIDTH-1:0] ram_wdata_o,
    output logic                   ram_oe_o,
    output logic                   ram_we_o,
    input  logic [`DATA_WIDTH-1:0] ram_rdata_i
);
    logic                    cpu_grant;    // Scheduler to CPU timing
    logic                    cpu_strobe;   // Transfer point of the CPU cycle
    logic                    cpu_done;     // CPU cycle finished
    logic                    ram_start;    // Access start to sequencer
    logic                    ram_done;     // Access finished
    pet_bus_pkg::bus_owner_t ram_owner;    // Owner of the starting access

    bus_scheduler i_bus_scheduler (
        .sys_clock_i   (sys_clock_i),
        .rst_n_i       (rst_n_i),
        .cpu_run_i     (cpu_run_i),
        .bridge_req_i  (bridge_req_i),
        .cpu_strobe_i  (cpu_strobe),
        .cpu_done_i    (cpu_done),
        .ram_done_i    (ram_done),
        .cpu_grant_o   (cpu_grant),
        .ram_start_o   (ram_start),
        .bridge_done_o (bridge_done_o),
        .ram_owner_o   (ram_owner)
    );

    cpu_bus_timing i_cpu_bus_timing (
        .sys_clock_i  (sys_clock_i),
        .rst_n_i      (rst_n_i),
        .cpu_grant_i  (cpu_grant),
        .cpu_be_o     (cpu_be_o),
        .cpu_clock_o  (cpu_clock_o),
        .cpu_strobe_o (cpu_strobe),
        .cpu_done_o   (cpu_done)
    );

    ram_sequencer i_ram_sequencer (
        .sys_clock_i    (sys_clock_i),
        .rst_n_i        (rst_n_i),
        .ram_start_i    (ram_start),
        .ram_owner_i    (ram_owner),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_we_i       (cpu_we_i),
        .cpu_data_i     (cpu_data_i),
        .bridge_addr_i  (bridge_addr_i),
        .bridge_we_i    (bridge_we_i),
        .bridge_wdata_i (bridge_wdata_i),
        .ram_rdata_i    (ram_rdata_i),
        .ram_addr_o     (ram_addr_o),
        .ram_wdata_o    (ram_wdata_o),
        .ram_oe_o       (ram_oe_o),
        .ram_we_o       (ram_we_o),
        .ram_done_o     (ram_done),
        .cpu_data_o     (cpu_data_o),
        .bridge_rdata_o (bridge_rdata_o)
    );

endmodule

`default_nettype wire

// ==== bench/pet_bus_tb.sv ====
// Run from the project root so the data file resolves; CPU cycles with no queued op read $FFFC
`include "pet_bus_config.svh"
`timescale 1ns/10ps
`default_nettype none

module pet_bus_tb;
    localparam int CLK_HALF_NS = 20;        // 40 ns period
    localparam int DRIVE_DELAY = 1;         // Input skew after the rising edge
    localparam int WAIT_CYCLES = 100;       // Timeout of every wait loop
    localparam int BE_WIDTH    = `CPU_BE_END - `CPU_BE_START;
    localparam int PHI_LEAD    = `CPU_PHI_START - `CPU_BE_START;
    localparam int PHI_WIDTH   = `CPU_PHI_END - `CPU_PHI_START;
    localparam int PHI_TRAIL   = `CPU_BE_END - `CPU_PHI_END;
    localparam logic [`ADDR_WIDTH-1:0] IDLE_ADDR = 16'hfffc;  // Dummy fetch of the reset vector

    logic                   sys_clock = 1'b0;
    logic                   rst_n, cpu_run;
    logic                   bridge_req, bridge_we, bridge_done;
    logic [`ADDR_WIDTH-1:0] bridge_addr, cpu_addr, ram_addr;
    logic [`DATA_WIDTH-1:0] bridge_wdata, bridge_rdata;
    logic                   cpu_be, cpu_clock, cpu_we;
    logic [`DATA_WIDTH-1:0] cpu_data_in, cpu_data_out;
    logic [`DATA_WIDTH-1:0] ram_wdata, ram_rdata;
    logic                   ram_oe, ram_we;

    logic [`DATA_WIDTH-1:0] sram   [0:65535];   // Behavioral async SRAM
    logic [`DATA_WIDTH-1:0] shadow [0:65535];   // Predicted memory contents

    int errors = 0;
    int ops = 0;
    int cpu_cycles = 0;
    bit timed_out = 1'b0;

    // Op handed from the main flow to the CPU pin model
    bit                     cpu_pend = 1'b0;
    bit                     cpu_op_done = 1'b0;
    logic                   pend_we;
    logic [`ADDR_WIDTH-1:0] pend_addr;
    logic [`DATA_WIDTH-1:0] pend_wdata, pend_file, pend_shadow;

    // Op of the CPU cycle on the bus now
    bit                     cycle_op = 1'b0;
    logic                   cycle_we = 1'b0;
    logic [`DATA_WIDTH-1:0] cycle_file, cycle_shadow;

    bit pin_be_q = 1'b0;                      // Pin model edge memory
    bit mon_be_q = 1'b0;                      // Monitor edge memory
    bit mon_phi_q = 1'b0;
    logic [`DATA_WIDTH-1:0] mon_data_q;       // CPU read data one sample back
    int be_len, phi_at, phi_len;              // Shape of the running CPU cycle

    always #(CLK_HALF_NS) sys_clock = ~sys_clock;

    // Async read, inverted garbage while output enable is low
    assign ram_rdata = ram_oe ? sram[ram_addr] : ~sram[ram_addr];
    always @(negedge ram_we) begin
        if (rst_n) sram[ram_addr] = ram_wdata;   // Latched at the end of the write pulse
    end

    pet_bus_top i_pet_bus_top (
        .sys_clock_i    (sys_clock),
        .rst_n_i        (rst_n),
        .cpu_run_i      (cpu_run),
        .bridge_req_i   (bridge_req),
        .bridge_we_i    (bridge_we),
        .bridge_addr_i  (bridge_addr),
        .bridge_wdata_i (bridge_wdata),
        .bridge_done_o  (bridge_done),
        .bridge_rdata_o (bridge_rdata),
        .cpu_be_o       (cpu_be),
        .cpu_clock_o    (cpu_clock),
        .cpu_addr_i     (cpu_addr),
        .cpu_we_i       (cpu_we),
        .cpu_data_i     (cpu_data_in),
        .cpu_data_o     (cpu_data_out),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .ram_oe_o       (ram_oe),
        .ram_we_o       (ram_we),
        .ram_rdata_i    (ram_rdata)
    );

    // Power-up contents that depend on every address bit
    function automatic logic [`DATA_WIDTH-1:0] fill_value(input logic [`ADDR_WIDTH-1:0] addr);
        return addr[15:8] ^ addr[7:0] ^ 8'h5a;
    endfunction

    task automatic report_mismatch(input string test, input int expected, input int actual);
        errors++;
        $display("FAILED %s: expected %0h, actual %0h", test, expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR %s", what);
    endtask

    // CPU pins take the queued op on each BE rise or else a dummy read
    always @(posedge sys_clock) begin
        #(DRIVE_DELAY);
        if (cpu_be && !pin_be_q) begin
            cycle_op     = cpu_pend;
            cycle_we     = cpu_pend ? pend_we : 1'b0;
            cycle_file   = pend_file;
            cycle_shadow = pend_shadow;
            cpu_addr     = cpu_pend ? pend_addr : IDLE_ADDR;
            cpu_we       = cycle_we;
            cpu_data_in  = pend_wdata;
            cpu_pend     = 1'b0;
        end
        pin_be_q = cpu_be;
    end

    // Bus monitor sampling registered outputs mid-cycle
    always @(negedge sys_clock) begin
        if (rst_n) begin
            if (cpu_clock && !cpu_be) report_problem("Phi2 high outside the bus enable window");
            if (ram_we && !cpu_be && !bridge_req) report_problem("SRAM write with no bus owner");
            if (cpu_be) begin
                if (!mon_be_q) begin
                    be_len  = 0;
                    phi_at  = 0;
                    phi_len = 0;
                end
                be_len++;
                if (cpu_clock) begin
                    if (!mon_phi_q) phi_at = be_len - 1;    // Cycles since BE rose
                    phi_len++;
                end
            end
            // CPU latches what was on its data pins as Phi2 fell
            if (!cpu_clock && mon_phi_q && cycle_op && !cycle_we) begin
                if (mon_data_q !== cycle_file)
                    report_mismatch("cpu_read_file", cycle_file, mon_data_q);
                if (mon_data_q !== cycle_shadow)
                    report_mismatch("cpu_read_shadow", cycle_shadow, mon_data_q);
            end
            if (!cpu_be && mon_be_q) begin
                if (be_len != BE_WIDTH) report_mismatch("be_width", BE_WIDTH, be_len);
                if (phi_at != PHI_LEAD) report_mismatch("phi_lead", PHI_LEAD, phi_at);
                if (phi_len != PHI_WIDTH) report_mismatch("phi_width", PHI_WIDTH, phi_len);
                if (be_len - phi_at - phi_len != PHI_TRAIL)
                    report_mismatch("phi_trail", PHI_TRAIL, be_len - phi_at - phi_len);
                cpu_cycles++;
                if (cycle_op) cpu_op_done = 1'b1;
            end
        end
        mon_be_q   = cpu_be;
        mon_phi_q  = cpu_clock;
        mon_data_q = cpu_data_out;
    end

    task automatic run_bridge_op(input logic we, input logic [`ADDR_WIDTH-1:0] addr,
                                 input logic [`DATA_WIDTH-1:0] wdata,
                                 input logic [`DATA_WIDTH-1:0] exp_data);
        int wait_count;
        bit seen;
        seen = 1'b0;
        @(posedge sys_clock);
        #(DRIVE_DELAY);
        bridge_req   = 1'b1;            // Held until done
        bridge_we    = we;
        bridge_addr  = addr;
        bridge_wdata = wdata;
        for (wait_count = 0; wait_count < WAIT_CYCLES && !seen; wait_count++) begin
            @(negedge sys_clock);
            seen = bridge_done;
        end
        if (!seen) begin
            report_problem("bridge access did not finish in time");
            timed_out = 1'b1;
        end else if (we) begin
            if (sram[addr] !== wdata) report_mismatch("bridge_write", wdata, sram[addr]);
            shadow[addr] = wdata;
        end else begin
            if (bridge_rdata !== exp_data)
                report_mismatch("bridge_read_file", exp_data, bridge_rdata);
            if (bridge_rdata !== shadow[addr])
                report_mismatch("bridge_read_shadow", shadow[addr], bridge_rdata);
        end
        @(posedge sys_clock);
        #(DRIVE_DELAY);
        bridge_req = 1'b0;
    endtask

    task automatic run_cpu_op(input logic we, input logic [`ADDR_WIDTH-1:0] addr,
                              input logic [`DATA_WIDTH-1:0] wdata,
                              input logic [`DATA_WIDTH-1:0] exp_data);
        int wait_count;
        if (!cpu_run) begin
            @(posedge sys_clock);
            #(DRIVE_DELAY);
            cpu_run = 1'b1;             // CPU keeps running from here on
        end
        @(negedge sys_clock);           // Away from the pin model's edge
        pend_we     = we;
        pend_addr   = addr;
        pend_wdata  = wdata;
        pend_file   = exp_data;
        pend_shadow = shadow[addr];
        cpu_op_done = 1'b0;
        cpu_pend    = 1'b1;
        for (wait_count = 0; wait_count < WAIT_CYCLES && !cpu_op_done; wait_count++)
            @(posedge sys_clock);
        if (!cpu_op_done) begin
            report_problem("CPU cycle of a queued operation did not finish in time");
            timed_out = 1'b1;
        end else if (we) begin
            if (sram[addr] !== wdata) report_mismatch("cpu_write", wdata, sram[addr]);
            shadow[addr] = wdata;
        end
    endtask

    initial begin
        int fd;
        int who;
        int we;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
        logic [`DATA_WIDTH-1:0] exp_data;
        logic [8*96-1:0]        line;
        rst_n        = 1'b0;
        cpu_run      = 1'b0;
        bridge_req   = 1'b0;
        bridge_we    = 1'b0;
        bridge_addr  = '0;
        bridge_wdata = '0;
        cpu_addr     = IDLE_ADDR;
        cpu_we       = 1'b0;
        cpu_data_in  = '0;
        for (int i = 0; i < 65536; i++) begin
            sram[i]   = fill_value(16'(i));
            shadow[i] = fill_value(16'(i));
        end
        repeat (2) @(posedge sys_clock);
        #(DRIVE_DELAY);
        rst_n = 1'b1;

        // Quiet bus with nobody asking
        repeat (20) begin
            @(negedge sys_clock);
            if (cpu_be || cpu_clock || ram_oe || ram_we || bridge_done)
                report_problem("output active after reset with no requests");
        end

        fd = $fopen("bench/pet_bus_testdata.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open the stimulus file");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = '0;
                if ($fgets(line, fd) > 0 &&
                    $sscanf(line, "%d %d %h %h %h", who, we, addr, wdata, exp_data) == 5) begin
                    if (who == 1) run_bridge_op(we[0], addr, wdata, exp_data);
                    else run_cpu_op(we[0], addr, wdata, exp_data);
                    ops++;
                end
            end
            $fclose(fd);
        end

        repeat (4) @(posedge sys_clock);
        $display("operations %0d, CPU cycles %0d, errors %0d", ops, cpu_cycles, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/pet_bus_testdata.txt ====
# requester (1 = host bridge, 0 = CPU), we (1 = write), addr, wdata, expected read data
# all values hex except the first two; expected read data is unused for writes
1 1 0200 a5 00
1 0 0200 00 a5
1 1 0201 3c 00
1 0 0201 00 3c
1 0 1234 00 7c
1 1 7fff 81 00
1 0 7fff 00 81
0 1 0300 5e 00
0 0 0300 00 5e
0 0 ffff 00 5a
0 1 0301 c7 00
0 0 0301 00 c7
1 1 0400 11 00
0 0 0400 00 11
0 1 0401 22 00
1 0 0401 00 22
1 1 0300 99 00
0 0 0300 00 99
0 0 0200 00 a5
1 0 0300 00 99
1 1 abcd 6b 00
0 0 abcd 00 6b
1 0 0301 00 c7

// ==== filelist.f ====
+incdir+src
src/pet_bus_pkg.sv
src/cpu_bus_timing.sv
src/bus_scheduler.sv
src/ram_sequencer.sv
src/pet_bus_top.sv
bench/pet_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pet_bus_tb \
    --Mdir obj_dir -o pet_bus_sim \
    -f filelist.f

./obj_dir/pet_bus_sim | tee sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
